//--- src/lsu_isa_pkg.sv
package lsu_isa_pkg;

    // ------------------------------
    // data width and operations
    // ------------------------------
    localparam int XLEN = 32;

    // low two bits follow funct3 size, bit 2 marks unsigned, bit 3 marks store
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } size_e;

    // trap causes for misaligned accesses
    localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
    localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;

    function automatic size_e op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return SIZE_B;
            LH, LHU, SH: return SIZE_H;
            default:     return SIZE_W;
        endcase
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        case (op)
            SB, SH, SW: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

endpackage

//--- src/lsu_cfg_pkg.sv
package lsu_cfg_pkg;
    import lsu_isa_pkg::*;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int ADDR_W     = 32;
    localparam int BE_W       = XLEN / 8;
    localparam int TRANS_ID_W = 4;

    // defaults picked up by the top level
    localparam int DEF_QUEUE_DEPTH      = 4;
    localparam int DEF_MEM_WORDS        = 256;
    localparam int DEF_RESULT_PIPE_REGS = 1;

    // one queued request, store data already on its byte lanes
    typedef struct packed {
        lsu_op_e               op;
        logic [ADDR_W-1:0]     addr;
        logic [XLEN-1:0]       wdata;
        logic [BE_W-1:0]       be;
        logic [TRANS_ID_W-1:0] trans_id;
        logic                  misaligned;
    } lsu_req_t;

endpackage

//--- src/lsu_req_if.sv
`timescale 1ns/10ps

interface lsu_req_if import lsu_isa_pkg::*, lsu_cfg_pkg::*;;

    logic                  valid;
    lsu_op_e               op;
    logic [ADDR_W-1:0]     addr;
    logic [XLEN-1:0]       wdata;
    logic [BE_W-1:0]       be;
    logic [TRANS_ID_W-1:0] trans_id;
    logic                  misaligned;
    // one pulse per freed receiver entry
    logic                  credit;

    modport sender (
        output valid, op, addr, wdata, be, trans_id, misaligned,
        input  credit
    );

    modport receiver (
        input  valid, op, addr, wdata, be, trans_id, misaligned,
        output credit
    );

endinterface

//--- src/lsu_issue.sv
`timescale 1ns/10ps

module lsu_issue import lsu_isa_pkg::*, lsu_cfg_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_valid_i,
    input  lsu_op_e               req_op_i,
    input  logic [XLEN-1:0]       req_base_i,
    input  logic [XLEN-1:0]       req_imm_i,
    input  logic [XLEN-1:0]       req_wdata_i,
    input  logic [TRANS_ID_W-1:0] req_trans_id_i,
    output logic                  req_ready_o,
    lsu_req_if.sender             q_o
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [ADDR_W-1:0] addr;
    size_e             size;
    logic [BE_W-1:0]   be;
    logic [XLEN-1:0]   wdata_lanes;
    logic              misaligned;
    logic              accept;
    logic [CNT_W-1:0]  credit_cnt;

    // ------------------------------
    // address generation
    // ------------------------------
    assign addr = $unsigned($signed(req_base_i) + $signed(req_imm_i));
    assign size = op_size(req_op_i);

    // byte enables and store lanes
    always_comb begin
        case (size)
            SIZE_B:  be = BE_W'(4'b0001) << addr[1:0];
            SIZE_H:  be = BE_W'(4'b0011) << addr[1:0];
            default: be = '1;
        endcase
    end

    assign wdata_lanes = req_wdata_i << {addr[1:0], 3'b000};

    // byte accesses never trap
    always_comb begin
        case (size)
            SIZE_H:  misaligned = addr[0];
            SIZE_W:  misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // ------------------------------
    // credits and output register
    // ------------------------------
    assign req_ready_o = (credit_cnt != '0);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_cnt <= CNT_W'(QUEUE_DEPTH);
            q_o.valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(accept) + CNT_W'(q_o.credit);
            q_o.valid  <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            q_o.op         <= req_op_i;
            q_o.addr       <= addr;
            q_o.wdata      <= wdata_lanes;
            q_o.be         <= be;
            q_o.trans_id   <= req_trans_id_i;
            q_o.misaligned <= misaligned;
        end
    end

    // returned credits can never outnumber the queue entries
    credit_bound_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) credit_cnt <= CNT_W'(QUEUE_DEPTH)
    );

endmodule

//--- src/lsu_req_queue.sv
`timescale 1ns/10ps

module lsu_req_queue import lsu_cfg_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    lsu_req_if.receiver in_i,
    lsu_req_if.sender   out_o
);

    localparam int PTR_W        = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W        = $clog2(QUEUE_DEPTH + 1);
    // entries in the consumer input FIFO
    localparam int DOWN_CREDITS = 2;
    localparam int DCRED_W      = $clog2(DOWN_CREDITS + 1);

    lsu_req_t           entries [QUEUE_DEPTH];
    lsu_req_t           head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [DCRED_W-1:0] down_credits;
    logic               push;
    logic               send;

    assign push = in_i.valid;
    assign send = (count != '0) && (down_credits != '0);
    assign head = entries[rd_ptr];

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            entries[wr_ptr] <= '{
                op:         in_i.op,
                addr:       in_i.addr,
                wdata:      in_i.wdata,
                be:         in_i.be,
                trans_id:   in_i.trans_id,
                misaligned: in_i.misaligned
            };
        end
        if (send) begin
            out_o.op         <= head.op;
            out_o.addr       <= head.addr;
            out_o.wdata      <= head.wdata;
            out_o.be         <= head.be;
            out_o.trans_id   <= head.trans_id;
            out_o.misaligned <= head.misaligned;
        end
    end

    // ------------------------------
    // pointers and credits
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            down_credits <= DCRED_W'(DOWN_CREDITS);
            out_o.valid  <= 1'b0;
            in_i.credit  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + CNT_W'(push) - CNT_W'(send);
            down_credits <= down_credits - DCRED_W'(send) + DCRED_W'(out_o.credit);
            out_o.valid  <= send;
            // entry leaves, upstream slot is free again
            in_i.credit  <= send;
        end
    end

    // the issue stage only sends while it owns a credit
    no_push_when_full_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) in_i.valid |-> (count != CNT_W'(QUEUE_DEPTH))
    );

endmodule

//--- src/lsu_mem_unit.sv
`timescale 1ns/10ps

module lsu_mem_unit import lsu_isa_pkg::*, lsu_cfg_pkg::*; #(
    parameter int MEM_WORDS        = 256,
    parameter int RESULT_PIPE_REGS = 1
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    lsu_req_if.receiver           in_i,
    output logic                  res_valid_o,
    output logic [TRANS_ID_W-1:0] res_trans_id_o,
    output logic [XLEN-1:0]       res_data_o,
    output logic                  ex_valid_o,
    output logic [3:0]            ex_cause_o
);

    localparam int FIFO_DEPTH = 2;
    localparam int IDX_W      = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN-1:0]       data;
        logic [3:0]            cause;
    } res_pay_t;

    lsu_req_t        fifo_q [FIFO_DEPTH];
    logic            wr_ptr;
    logic            rd_ptr;
    logic [1:0]      fifo_cnt;
    lsu_req_t        head;
    logic            head_valid;
    logic            head_store;
    logic [IDX_W-1:0] head_idx;
    logic            st_phase;
    logic            finish;
    logic [XLEN-1:0] mem_q [MEM_WORDS];
    logic [XLEN-1:0] rd_word;
    logic [XLEN-1:0] rd_buf;
    logic [XLEN-1:0] lane_data;
    logic [XLEN-1:0] merged;
    logic [1:0]      flags_d;
    res_pay_t        pay_d;
    logic [1:0]      flags_q [RESULT_PIPE_REGS];
    res_pay_t        pay_q [RESULT_PIPE_REGS];

    // ------------------------------
    // input FIFO
    // ------------------------------
    assign head       = fifo_q[rd_ptr];
    assign head_valid = (fifo_cnt != 2'd0);
    assign head_store = op_is_store(head.op);
    assign head_idx   = IDX_W'((head.addr >> 2) % MEM_WORDS);

    // loads and traps finish at once, stores need the write cycle too
    assign finish = head_valid && (head.misaligned || !head_store || st_phase);

    always_ff @(posedge clk_i) begin
        if (in_i.valid) begin
            fifo_q[wr_ptr] <= '{
                op:         in_i.op,
                addr:       in_i.addr,
                wdata:      in_i.wdata,
                be:         in_i.be,
                trans_id:   in_i.trans_id,
                misaligned: in_i.misaligned
            };
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            fifo_cnt    <= 2'd0;
            st_phase    <= 1'b0;
            in_i.credit <= 1'b0;
        end else begin
            if (in_i.valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (finish) begin
                rd_ptr <= ~rd_ptr;
            end
            fifo_cnt    <= fifo_cnt + 2'(in_i.valid) - 2'(finish);
            st_phase    <= head_valid && head_store && !head.misaligned && !st_phase;
            in_i.credit <= finish;
        end
    end

    // ------------------------------
    // data memory
    // ------------------------------
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    assign rd_word = mem_q[head_idx];

    // only enabled lanes take the new bytes
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            merged[8*b +: 8] = head.be[b] ? head.wdata[8*b +: 8] : rd_buf[8*b +: 8];
        end
    end

    always @(posedge clk_i) begin
        if (head_valid && head_store && !head.misaligned && !st_phase) begin
            rd_buf <= rd_word;
        end
        if (finish && head_store && !head.misaligned) begin
            mem_q[head_idx] <= merged;
        end
    end

    // load lane select and extension
    always_comb begin
        lane_data = rd_word >> {head.addr[1:0], 3'b000};
        case (head.op)
            LB:      lane_data = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
            LBU:     lane_data = {{(XLEN-8){1'b0}}, lane_data[7:0]};
            LH:      lane_data = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
            LHU:     lane_data = {{(XLEN-16){1'b0}}, lane_data[15:0]};
            default: lane_data = rd_word;
        endcase
    end

    // ------------------------------
    // result pipeline
    // ------------------------------
    always_comb begin
        flags_d        = {finish, finish && head.misaligned};
        pay_d.trans_id = head.trans_id;
        pay_d.cause    = head_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        if (head.misaligned) begin
            pay_d.data = head.addr;
        end else if (head_store) begin
            pay_d.data = '0;
        end else begin
            pay_d.data = lane_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < RESULT_PIPE_REGS; i++) begin
                flags_q[i] <= 2'b00;
            end
        end else begin
            flags_q[0] <= flags_d;
            for (int i = 1; i < RESULT_PIPE_REGS; i++) begin
                flags_q[i] <= flags_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pay_q[0] <= pay_d;
        for (int i = 1; i < RESULT_PIPE_REGS; i++) begin
            pay_q[i] <= pay_q[i-1];
        end
    end

    assign res_valid_o    = flags_q[RESULT_PIPE_REGS-1][1];
    assign ex_valid_o     = flags_q[RESULT_PIPE_REGS-1][0];
    assign res_trans_id_o = pay_q[RESULT_PIPE_REGS-1].trans_id;
    assign res_data_o     = pay_q[RESULT_PIPE_REGS-1].data;
    assign ex_cause_o     = pay_q[RESULT_PIPE_REGS-1].cause;

    // queue credits keep this FIFO from overflowing
    fifo_overflow_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) in_i.valid |-> (fifo_cnt != 2'(FIFO_DEPTH))
    );

endmodule

//--- src/lsu_top.sv
`timescale 1ns/10ps

module lsu_top import lsu_isa_pkg::*, lsu_cfg_pkg::*; #(
    parameter int QUEUE_DEPTH      = DEF_QUEUE_DEPTH,
    parameter int MEM_WORDS        = DEF_MEM_WORDS,
    parameter int RESULT_PIPE_REGS = DEF_RESULT_PIPE_REGS
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // request side
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  lsu_op_e               req_op_i,
    input  logic [XLEN-1:0]       req_base_i,
    input  logic [XLEN-1:0]       req_imm_i,
    input  logic [XLEN-1:0]       req_wdata_i,
    input  logic [TRANS_ID_W-1:0] req_trans_id_i,
    // result side, always accepted
    output logic                  res_valid_o,
    output logic [TRANS_ID_W-1:0] res_trans_id_o,
    output logic [XLEN-1:0]       res_data_o,
    output logic                  ex_valid_o,
    output logic [3:0]            ex_cause_o
);

    lsu_req_if issue_q ();
    lsu_req_if q_mem ();

    lsu_issue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) u_issue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_base_i     (req_base_i),
        .req_imm_i      (req_imm_i),
        .req_wdata_i    (req_wdata_i),
        .req_trans_id_i (req_trans_id_i),
        .req_ready_o    (req_ready_o),
        .q_o            (issue_q)
    );

    lsu_req_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) u_req_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .in_i           (issue_q),
        .out_o          (q_mem)
    );

    lsu_mem_unit #(
        .MEM_WORDS        (MEM_WORDS),
        .RESULT_PIPE_REGS (RESULT_PIPE_REGS)
    ) u_mem_unit (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .in_i             (q_mem),
        .res_valid_o      (res_valid_o),
        .res_trans_id_o   (res_trans_id_o),
        .res_data_o       (res_data_o),
        .ex_valid_o       (ex_valid_o),
        .ex_cause_o       (ex_cause_o)
    );

endmodule

//--- tb/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu import lsu_isa_pkg::*, lsu_cfg_pkg::*;;

    localparam int N_REQ          = 400;
    localparam int WINDOW_WORDS   = 16;
    localparam int BURST_FIRST    = 200;
    localparam int BURST_LAST     = 259;
    localparam int TIMEOUT_CYCLES = N_REQ * 4 + 400;

    typedef struct packed {
        lsu_op_e         op;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] wdata;
    } stim_t;

    typedef struct packed {
        int unsigned           num;
        logic [TRANS_ID_W-1:0] id;
        logic [XLEN-1:0]       data;
        logic                  ex;
        logic [3:0]            cause;
    } exp_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  req_valid_i;
    logic                  req_ready_o;
    lsu_op_e               req_op_i;
    logic [XLEN-1:0]       req_base_i;
    logic [XLEN-1:0]       req_imm_i;
    logic [XLEN-1:0]       req_wdata_i;
    logic [TRANS_ID_W-1:0] req_trans_id_i;
    logic                  res_valid_o;
    logic [TRANS_ID_W-1:0] res_trans_id_o;
    logic [XLEN-1:0]       res_data_o;
    logic                  ex_valid_o;
    logic [3:0]            ex_cause_o;

    integer          seed = 46116;
    lsu_op_e         op_table [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
    logic [XLEN-1:0] model_mem [WINDOW_WORDS];
    exp_t            exp_q [$];
    exp_t            exp_r;
    int unsigned     n_results;
    int unsigned     cycle_cnt;
    logic            ready_fell;

    lsu_top u_lsu_top (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_op_i       (req_op_i),
        .req_base_i     (req_base_i),
        .req_imm_i      (req_imm_i),
        .req_wdata_i    (req_wdata_i),
        .req_trans_id_i (req_trans_id_i),
        .res_valid_o    (res_valid_o),
        .res_trans_id_o (res_trans_id_o),
        .res_data_o     (res_data_o),
        .ex_valid_o     (ex_valid_o),
        .ex_cause_o     (ex_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        assert (expected === actual) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    function automatic int op_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic stim_t make_stim(lsu_op_e op, int addr, int imm, logic [XLEN-1:0] wdata);
        stim_t s;
        s.op    = op;
        s.imm   = XLEN'(imm);
        s.base  = XLEN'(addr - imm);
        s.wdata = wdata;
        return s;
    endfunction

    // directed opening then random traffic with a store burst in the middle
    function automatic stim_t pick_request(int n);
        lsu_op_e op;
        int      addr;
        int      imm;
        case (n)
            0: return make_stim(SW, 8, 4, 32'ha5c3_0f81);
            1: return make_stim(LW, 8, -4, 32'h0);
            2: return make_stim(SW, 10, 2, 32'h1234_5678);
            3: return make_stim(LW, 8, 0, 32'h0);
            4: return make_stim(SB, 9, 1, 32'hffff_ff7e);
            5: return make_stim(LB, 11, -3, 32'h0);
            6: return make_stim(LHU, 10, 6, 32'h0);
            7: return make_stim(LH, 10, 0, 32'h0);
            default: ;
        endcase
        if (n >= BURST_FIRST && n <= BURST_LAST) begin
            op = op_table[5 + {$random(seed)} % 3];
        end else begin
            op = op_table[{$random(seed)} % 8];
        end
        addr = int'({$random(seed)} % (WINDOW_WORDS * 4));
        // mostly aligned so loads and stores really hit memory
        if ({$random(seed)} % 4 != 0) begin
            addr = addr - (addr % op_bytes(op));
        end
        imm = int'({$random(seed)} % 32) - 16;
        return make_stim(op, addr, imm, $random(seed));
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic exp_t ref_model(int unsigned num, stim_t s, logic [TRANS_ID_W-1:0] id);
        exp_t            e;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] val;
        logic            store;
        int              nbytes;
        int              w;
        int              lane;
        addr    = s.base + s.imm;
        store   = (s.op == SB) || (s.op == SH) || (s.op == SW);
        nbytes  = op_bytes(s.op);
        w       = int'((addr >> 2) % WINDOW_WORDS);
        word    = model_mem[w];
        val     = '0;
        e.num   = num;
        e.id    = id;
        e.ex    = (int'(addr[1:0]) % nbytes) != 0;
        e.cause = store ? 4'd6 : 4'd4;
        if (e.ex) begin
            e.data = addr;
            return e;
        end
        for (int i = 0; i < nbytes; i++) begin
            lane = int'(addr[1:0]) + i;
            if (store) begin
                word[8*lane +: 8] = s.wdata[8*i +: 8];
            end else begin
                val[8*i +: 8] = word[8*lane +: 8];
            end
        end
        if (s.op == LB || s.op == LH) begin
            for (int i = 8 * nbytes; i < XLEN; i++) begin
                val[i] = val[8*nbytes-1];
            end
        end
        model_mem[w] = word;
        e.data       = store ? '0 : val;
        return e;
    endfunction

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        stim_t s;
        logic  rdy;
        int    n_sent;
        int    idle;
        rst_ni         = 1'b0;
        req_valid_i    = 1'b0;
        req_op_i       = LW;
        req_base_i     = '0;
        req_imm_i      = '0;
        req_wdata_i    = '0;
        req_trans_id_i = '0;
        ready_fell     = 1'b0;
        n_sent         = 0;
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("reset res_valid", '0, 32'(res_valid_o));
        check_value("reset ex_valid", '0, 32'(ex_valid_o));
        check_value("reset req_ready", 32'd1, 32'(req_ready_o));
        @(posedge clk_i);
        while (n_sent < N_REQ) begin
            s = pick_request(n_sent);
            req_valid_i <= 1'b1;
            req_op_i    <= s.op;
            req_base_i  <= s.base;
            req_imm_i   <= s.imm;
            req_wdata_i <= s.wdata;
            do begin
                @(negedge clk_i);
                rdy = req_ready_o;
                if (!rdy && n_sent >= BURST_FIRST && n_sent <= BURST_LAST) begin
                    ready_fell = 1'b1;
                end
                @(posedge clk_i);
            end while (!rdy);
            // taken on this edge
            exp_q.push_back(ref_model(n_sent, s, req_trans_id_i));
            n_sent++;
            req_trans_id_i <= req_trans_id_i + 1'b1;
            idle = 0;
            if ((n_sent < BURST_FIRST || n_sent > BURST_LAST) && {$random(seed)} % 4 == 0) begin
                idle = 1 + int'({$random(seed)} % 3);
            end
            if (idle > 0) begin
                req_valid_i <= 1'b0;
                repeat (idle) @(posedge clk_i);
            end
        end
        req_valid_i <= 1'b0;
        while (n_results < N_REQ) begin
            @(posedge clk_i);
        end
        // stray results would still show up here
        repeat (4) @(posedge clk_i);
        assert (ready_fell) else begin
            $display("req_ready_o never went low during the store burst");
            fail_run();
        end
        $display("Done: no errors");
        $finish;
    end

    // ------------------------------
    // result comparison
    // ------------------------------
    always @(negedge clk_i) begin
        if (rst_ni && res_valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("result arrived with no request outstanding");
                fail_run();
            end
            exp_r = exp_q.pop_front();
            check_value($sformatf("req%0d trans_id", exp_r.num), 32'(exp_r.id),
                        32'(res_trans_id_o));
            check_value($sformatf("req%0d ex_valid", exp_r.num), 32'(exp_r.ex),
                        32'(ex_valid_o));
            check_value($sformatf("req%0d data", exp_r.num), exp_r.data, res_data_o);
            if (exp_r.ex) begin
                check_value($sformatf("req%0d cause", exp_r.num), 32'(exp_r.cause),
                            32'(ex_cause_o));
            end
            n_results++;
        end else if (rst_ni) begin
            check_value("idle ex_valid", '0, 32'(ex_valid_o));
        end
    end

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d results", cycle_cnt, n_results);
            fail_run();
        end
    end

endmodule

//--- build.f
src/lsu_isa_pkg.sv
src/lsu_cfg_pkg.sv
src/lsu_req_if.sv
src/lsu_issue.sv
src/lsu_req_queue.sv
src/lsu_mem_unit.sv
src/lsu_top.sv
tb/tb_lsu.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_lsu -o tb_lsu

output=$(./obj_dir/tb_lsu 2>&1) || true
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
    exit 0
fi
exit 1
